// ==== bench/pattern_recognition_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module pattern_recognition_asserts (
    input logic               clk,
    input logic               reset,
    input logic               y_valid,
    input logic               y_ready,
    input vision_pkg::pixel_t y_data,
    input logic               detection_valid
);

    // Stalled output beat keeps valid and its pixel
    a_y_hold: assert property (@(posedge clk) disable iff (reset)
        (y_valid && !y_ready) |=> (y_valid && $stable(y_data)))
        else $error("y_data or y_valid changed while the output was stalled");

    // Frame verdict pulse
    a_det_pulse: assert property (@(posedge clk) disable iff (reset)
        detection_valid |=> !detection_valid)
        else $error("detection_valid stayed high for more than one cycle");

    a_reset_clean: assert property (@(posedge clk)
        $fell(reset) |-> (!y_valid && !detection_valid))
        else $error("y_valid or detection_valid high in the cycle after reset");

endmodule

bind pattern_recognition pattern_recognition_asserts u_asserts (
    .clk             (clk),
    .reset           (reset),
    .y_valid         (y_valid),
    .y_ready         (y_ready),
    .y_data          (y_data),
    .detection_valid (detection_valid)
);

`default_nettype wire

// ==== bench/tb_pattern_recognition.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_pattern_recognition;
    import vision_pkg::*;

    localparam int IMG_PIX         = IMG_WIDTH * IMG_HEIGHT;   // Input beats per frame
    localparam int OUT_PIX         = OUT_WIDTH * OUT_HEIGHT;   // 84 filtered beats
    localparam int NUM_FRAMES      = 10;
    localparam int RESET_CYCLES    = 5;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * 4 * IMG_PIX + RESET_CYCLES;
    localparam int PIX_MAX         = (1 << PIX_W) - 1;
    localparam int COUNT_MAX       = (1 << COUNT_W) - 1;
    localparam logic [PIX_W-1:0] DARK = 8'd16;                 // Road surface

    typedef enum logic [1:0] {STRIPES, RANDOM, RAMP} image_kind_t;

    typedef struct packed {
        kernel_t            kernel;
        image_kind_t        kind;
        logic [4:0]         width;          // Stripe length, ends at right border
        logic [PIX_W-1:0]   level;          // Stripe grey level
        logic               random_ready;   // Else y_ready stays high
        logic               exp_flag;
        logic [COUNT_W-1:0] exp_count;
    } frame_t;

    // ======================================================================
    // Kernels, coef[8] written first so rows and columns read mirrored
    // ======================================================================
    localparam kernel_t K_IDENTITY = kernel_t'({8'sd0, 8'sd0, 8'sd0,
                                                8'sd0, 8'sd1, 8'sd0,
                                                8'sd0, 8'sd0, 8'sd0});
    localparam kernel_t K_SOBEL    = kernel_t'({8'sd1, 8'sd0, -8'sd1,
                                                8'sd2, 8'sd0, -8'sd2,
                                                8'sd1, 8'sd0, -8'sd1});   // Right minus left
    localparam kernel_t K_SOBEL2   = kernel_t'({8'sd2, 8'sd0, -8'sd2,
                                                8'sd4, 8'sd0, -8'sd4,
                                                8'sd2, 8'sd0, -8'sd2});
    localparam kernel_t K_SOBEL2_N = kernel_t'({-8'sd2, 8'sd0, 8'sd2,
                                                -8'sd4, 8'sd0, 8'sd4,
                                                -8'sd2, 8'sd0, 8'sd2});
    localparam kernel_t K_HDIFF    = kernel_t'({8'sd0, 8'sd0, 8'sd0,
                                                -8'sd1, 8'sd1, 8'sd0,
                                                8'sd0, 8'sd0, 8'sd0});    // Centre minus right

    logic               clk;
    logic               reset;
    logic               x_valid;
    logic               x_ready;
    pixel_t             x_data;
    kernel_t            kernel;
    logic               y_valid;
    logic               y_ready;
    pixel_t             y_data;
    logic               crossing_detected;
    logic [COUNT_W-1:0] long_run_count;
    logic               detection_valid;

    frame_t             frames [NUM_FRAMES];
    pixel_t             img [IMG_HEIGHT][IMG_WIDTH];
    pixel_t             exp_pix [OUT_PIX];      // Raster order
    logic               model_flag;
    logic [COUNT_W-1:0] model_count;
    logic [31:0]        lcg_state = 32'h42e05e36;

    pattern_recognition DUT (
        .clk               (clk),
        .reset             (reset),
        .x_valid           (x_valid),
        .x_ready           (x_ready),
        .x_data            (x_data),
        .kernel            (kernel),
        .y_valid           (y_valid),
        .y_ready           (y_ready),
        .y_data            (y_data),
        .crossing_detected (crossing_detected),
        .long_run_count    (long_run_count),
        .detection_valid   (detection_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;    // 20 ns period
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // ======================================================================
    // Failure reporting and compare tasks
    // ======================================================================
    task automatic stop_on_failure();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        stop_on_failure();
    endtask

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            report_mismatch(name, 32'(got.value), 32'(exp.value));
        end
    endtask

    task automatic check_result(input string who, input logic got_flag,
                                input logic [COUNT_W-1:0] got_count, input logic exp_flag,
                                input logic [COUNT_W-1:0] exp_count);
        if (got_flag !== exp_flag) begin
            report_mismatch({who, " crossing_detected"}, 32'(got_flag), 32'(exp_flag));
        end else if (got_count !== exp_count) begin
            report_mismatch({who, " long_run_count"}, 32'(got_count), 32'(exp_count));
        end
    endtask

    task automatic check_reset();
        if (y_valid !== 1'b0) begin
            report_mismatch("y_valid", 32'(y_valid), 32'd0);
        end else if (detection_valid !== 1'b0) begin
            report_mismatch("detection_valid", 32'(detection_valid), 32'd0);
        end else if (crossing_detected !== 1'b0) begin
            report_mismatch("crossing_detected", 32'(crossing_detected), 32'd0);
        end else if (long_run_count !== '0) begin
            report_mismatch("long_run_count", 32'(long_run_count), 32'd0);
        end else if (x_ready !== 1'b1) begin
            report_mismatch("x_ready", 32'(x_ready), 32'd1);   // Empty output slot
        end
    endtask

    // ======================================================================
    // Image generation and reference model
    // ======================================================================
    task automatic build_image(input frame_t fr);
        for (int y = 0; y < IMG_HEIGHT; y++) begin
            for (int x = 0; x < IMG_WIDTH; x++) begin
                case (fr.kind)
                    STRIPES: begin
                        // Odd rows carry a stripe touching the right border
                        img[y][x].value = (y % 2 == 1 && x >= IMG_WIDTH - int'(fr.width)) ?
                                          fr.level : DARK;
                    end
                    RAMP: img[y][x].value = PIX_W'(x * 16 + y);   // Slope 16 per column
                    default: begin
                        lcg_state = lcg_next(lcg_state);
                        img[y][x].value = 8'd64 + {2'b00, lcg_state[29:24]};   // Low contrast
                    end
                endcase
            end
        end
    endtask

    task automatic compute_model(input kernel_t kern);
        int   acc;
        int   run;
        int   votes;
        int   hi;
        int   lo;
        int   sum;
        int   lane_count [NUM_LANES];
        logic white;
        for (int r = 0; r < OUT_HEIGHT; r++) begin
            for (int c = 0; c < OUT_WIDTH; c++) begin
                acc = 0;
                for (int i = 0; i < KERNEL_H; i++) begin
                    for (int j = 0; j < KERNEL_W; j++) begin
                        acc += int'(img[r+i][c+j].value)
                             * int'($signed(kern.coef[i*KERNEL_W + j]));
                    end
                end
                acc = acc >>> W_FRAC;
                exp_pix[r*OUT_WIDTH + c].value = (acc < 0) ? '0 :
                                                 (acc > PIX_MAX) ? '1 : PIX_W'(acc);
            end
        end
        votes = 0;
        for (int l = 0; l < NUM_LANES; l++) begin
            lane_count[l] = 0;
            for (int r = 0; r < OUT_HEIGHT; r++) begin
                run = 0;
                for (int c = 0; c < OUT_WIDTH; c++) begin
                    white = (exp_pix[r*OUT_WIDTH + c].value >= LANE_THRESHOLD[l]);
                    if (white) begin
                        run++;
                    end
                    if (!white || c == OUT_WIDTH - 1) begin   // Run closes here
                        if (run >= MIN_RUN_LENGTH && lane_count[l] < COUNT_MAX) begin
                            lane_count[l]++;
                        end
                        run = 0;
                    end
                end
            end
            if (lane_count[l] >= MIN_STRIPES) begin
                votes++;
            end
        end
        hi  = lane_count[0];
        lo  = lane_count[0];
        sum = 0;
        for (int l = 0; l < NUM_LANES; l++) begin
            hi  = (lane_count[l] > hi) ? lane_count[l] : hi;
            lo  = (lane_count[l] < lo) ? lane_count[l] : lo;
            sum += lane_count[l];
        end
        model_flag  = (votes >= 2);
        model_count = COUNT_W'(sum - hi - lo);                // Median of three
    endtask

    // ======================================================================
    // Frame driver and monitor
    // ======================================================================
    task automatic drive_ready(input logic random_ready);
        if (random_ready) begin
            lcg_state = lcg_next(lcg_state);
            y_ready  <= lcg_state[31];
        end else begin
            y_ready <= 1'b1;
        end
    endtask

    task automatic run_frame(input frame_t fr);
        int n_in;
        int n_out;
        bit done;
        n_in    = 0;
        n_out   = 0;
        done    = 1'b0;
        kernel  <= fr.kernel;        // Pipeline is empty between frames
        x_valid <= 1'b1;
        x_data  <= img[0][0];
        drive_ready(fr.random_ready);
        while (!done) begin
            @(posedge clk);
            // Handshakes as the DUT sees them at this edge
            if (x_valid && x_ready) begin
                n_in++;
            end
            if (y_valid && y_ready) begin
                if (n_out >= OUT_PIX) begin
                    $display("Filter sent more than %0d pixels in one frame", OUT_PIX);
                    stop_on_failure();
                end else begin
                    check_pixel($sformatf("y_data[%0d]", n_out), y_data, exp_pix[n_out]);
                    n_out++;
                end
            end
            if (detection_valid) begin
                if (n_out != OUT_PIX) begin
                    report_mismatch("output pixel count", 32'(n_out), 32'(OUT_PIX));
                end else begin
                    check_result("DUT", crossing_detected, long_run_count,
                                 model_flag, model_count);
                    done = 1'b1;
                end
            end
            x_valid <= (n_in < IMG_PIX);
            if (n_in < IMG_PIX) begin
                x_data <= img[n_in / IMG_WIDTH][n_in % IMG_WIDTH];   // Held until taken
            end
            drive_ready(fr.random_ready);
        end
    endtask

    initial begin
        reset   = 1'b1;
        x_valid = 1'b0;
        x_data  = '0;
        y_ready = 1'b0;
        kernel  = K_IDENTITY;
        // Stripe frames: output run is width-1, three stripe rows in the interior
        frames[0] = '{K_IDENTITY, STRIPES, 5'd8, 8'd250, 1'b0, 1'b1, 8'd3};
        frames[1] = '{K_IDENTITY, STRIPES, 5'd8, 8'd250, 1'b1, 1'b1, 8'd3};  // Stalls
        frames[2] = '{K_IDENTITY, STRIPES, 5'd5, 8'd200, 1'b0, 1'b1, 8'd3};  // Lane 2 dark
        frames[3] = '{K_IDENTITY, STRIPES, 5'd4, 8'd250, 1'b1, 1'b0, 8'd0};  // Runs of 3
        frames[4] = '{K_IDENTITY, STRIPES, 5'd8, 8'd150, 1'b0, 1'b0, 8'd0};  // Lane 0 only
        frames[5] = '{K_IDENTITY, RANDOM, 5'd0, 8'd0, 1'b1, 1'b0, 8'd0};
        frames[6] = '{K_SOBEL, RAMP, 5'd0, 8'd0, 1'b0, 1'b0, 8'd0};     // 128, counts 6 0 0
        frames[7] = '{K_SOBEL2, RAMP, 5'd0, 8'd0, 1'b1, 1'b1, 8'd6};    // Clamps at 255
        frames[8] = '{K_SOBEL2_N, RAMP, 5'd0, 8'd0, 1'b0, 1'b0, 8'd0};  // Clamps at 0
        frames[9] = '{K_HDIFF, RANDOM, 5'd0, 8'd0, 1'b1, 1'b0, 8'd0};
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_reset();
        for (int f = 0; f < NUM_FRAMES; f++) begin
            build_image(frames[f]);
            compute_model(frames[f].kernel);
            check_result("model", model_flag, model_count,
                         frames[f].exp_flag, frames[f].exp_count);
            run_frame(frames[f]);
        end
        $display("All tests passed!");
        $finish;
    end

    // Watchdog, four cycles per input pixel is ample even under stalls
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: frames still running after %0d clock cycles", WATCHDOG_CYCLES);
        stop_on_failure();
    end

endmodule

`default_nettype wire

// ==== files.f ====
hw/vision_pkg.sv
hw/line_window.sv
hw/convolution_filter.sv
hw/stripe_detector.sv
hw/crossing_vote.sv
hw/pattern_recognition.sv
bench/pattern_recognition_asserts.sv
bench/tb_pattern_recognition.sv

// ==== hw/convolution_filter.sv ====
`timescale 1ns/100ps
`default_nettype none

module convolution_filter (
    input  logic                 clk,
    input  logic                 reset,
    // Camera side
    input  logic                 x_valid,
    output logic                 x_ready,
    input  vision_pkg::pixel_t   x_data,
    // Coefficients, held by the caller
    input  vision_pkg::kernel_t  kernel,
    // Filtered side
    output logic                 y_valid,
    input  logic                 y_ready,
    output vision_pkg::pixel_t   y_data
);
    import vision_pkg::*;

    localparam logic signed [ACC_W-1:0] PIX_MAX = ACC_W'((1 << PIX_W) - 1);   // 255

    logic                    shift_en;      // Input beat accepted
    pixel_t [KERNEL_N-1:0]   window;
    logic                    window_full;   // This beat closes an interior window
    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] scaled;
    pixel_t                  filtered;

    // ======================================================================
    // Handshake
    // ======================================================================
    assign x_ready  = !y_valid || y_ready;   // Output slot empty or draining
    assign shift_en = x_valid && x_ready;

    line_window u_line_window (
        .clk         (clk),
        .reset       (reset),
        .shift_en    (shift_en),
        .pixel       (x_data),
        .window      (window),
        .window_full (window_full)
    );

    // ======================================================================
    // Multiply-accumulate
    // ======================================================================
    always_comb begin
        logic signed [ACC_W-1:0] prod;
        acc = '0;
        for (int i = 0; i < KERNEL_N; i++) begin
            // Pixel as positive signed, coefficient already signed
            prod = $signed({1'b0, window[i].value}) * $signed(kernel.coef[i]);
            acc  = acc + prod;
        end
    end

    assign scaled = acc >>> W_FRAC;            // Keeps sign

    // Clamp to grey range
    always_comb begin
        if (scaled < 0) begin
            filtered.value = '0;
        end else if (scaled > PIX_MAX) begin
            filtered.value = '1;               // Saturate at 255
        end else begin
            filtered.value = scaled[PIX_W-1:0];
        end
    end

    // ======================================================================
    // Output register
    // ======================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            y_valid <= 1'b0;
        end else if (window_full) begin
            y_valid <= 1'b1;                   // New pixel next cycle
        end else if (y_ready) begin
            y_valid <= 1'b0;                   // Drained, nothing new
        end
    end

    always_ff @(posedge clk) begin
        if (window_full) begin
            y_data <= filtered;                // Held while stalled
        end
    end

endmodule

`default_nettype wire

// ==== hw/crossing_vote.sv ====
`timescale 1ns/100ps
`default_nettype none

module crossing_vote (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic                                                 lane_valid,
    input  vision_pkg::lane_result_t [vision_pkg::NUM_LANES-1:0] lanes,
    output logic                                                 crossing_detected,
    output logic [vision_pkg::COUNT_W-1:0]                       long_run_count,
    output logic                                                 detection_valid
);
    import vision_pkg::*;

    logic               majority;   // Two of three lanes agree
    logic [COUNT_W-1:0] lo_ab;
    logic [COUNT_W-1:0] hi_ab;
    logic [COUNT_W-1:0] lo_hi_c;
    logic [COUNT_W-1:0] median;

    assign majority = (lanes[0].detected && lanes[1].detected)
                   || (lanes[0].detected && lanes[2].detected)
                   || (lanes[1].detected && lanes[2].detected);

    // Median of three as max(min(a,b), min(max(a,b),c))
    always_comb begin
        lo_ab   = (lanes[0].long_run_count < lanes[1].long_run_count) ?
                  lanes[0].long_run_count : lanes[1].long_run_count;
        hi_ab   = (lanes[0].long_run_count < lanes[1].long_run_count) ?
                  lanes[1].long_run_count : lanes[0].long_run_count;
        lo_hi_c = (hi_ab < lanes[2].long_run_count) ? hi_ab : lanes[2].long_run_count;
        median  = (lo_ab > lo_hi_c) ? lo_ab : lo_hi_c;
    end

    // ======================================================================
    // Frame result register
    // ======================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            crossing_detected <= 1'b0;
            long_run_count    <= '0;
            detection_valid   <= 1'b0;
        end else begin
            detection_valid <= lane_valid;       // One cycle behind the lanes
            if (lane_valid) begin
                crossing_detected <= majority;   // Held until next frame
                long_run_count    <= median;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/line_window.sv ====
`timescale 1ns/100ps
`default_nettype none

module line_window (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic                                           shift_en,
    input  vision_pkg::pixel_t                             pixel,
    output vision_pkg::pixel_t [vision_pkg::KERNEL_N-1:0]  window,
    output logic                                           window_full
);
    import vision_pkg::*;

    // ======================================================================
    // Storage
    // ======================================================================
    pixel_t row_buf_1 [IMG_WIDTH];    // Previous row, r-1
    pixel_t row_buf_2 [IMG_WIDTH];    // Oldest row, r-2
    pixel_t above_1;                  // Column read of row r-1
    pixel_t above_2;                  // Column read of row r-2

    // Two older columns per window row, [row][0] is leftmost
    pixel_t [KERNEL_H-1:0][KERNEL_W-2:0] taps;

    logic [COL_W-1:0] col;            // Column of the incoming pixel
    logic [ROW_W-1:0] row;            // Row of the incoming pixel
    logic             last_col;
    logic             last_row;

    assign above_1 = row_buf_1[col];
    assign above_2 = row_buf_2[col];

    // Window as seen by this shift, newest column taken live
    always_comb begin
        pixel_t [KERNEL_H-1:0] live;
        live[0] = above_2;            // Oldest row on top
        live[1] = above_1;
        live[2] = pixel;
        for (int r = 0; r < KERNEL_H; r++) begin
            for (int c = 0; c < KERNEL_W - 1; c++) begin
                window[r*KERNEL_W + c] = taps[r][c];
            end
            window[r*KERNEL_W + KERNEL_W - 1] = live[r];
        end
    end

    assign last_col = (col == COL_W'(IMG_WIDTH - 1));
    assign last_row = (row == ROW_W'(IMG_HEIGHT - 1));

    // Interior only, so no padding at the borders
    assign window_full = shift_en
                      && (row >= ROW_W'(KERNEL_H - 1))
                      && (col >= COL_W'(KERNEL_W - 1));

    // ======================================================================
    // Raster position
    // ======================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            col <= '0;                                  // Back to frame start
            row <= '0;
        end else if (shift_en) begin
            if (last_col) begin
                col <= '0;
                row <= last_row ? '0 : row + 1'b1;      // Wrap at frame end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // Line buffers move one row down at this column
    always_ff @(posedge clk) begin
        if (shift_en) begin
            row_buf_2[col] <= above_1;
            row_buf_1[col] <= pixel;
        end
    end

    // Shift window left by one column
    always_ff @(posedge clk) begin
        if (shift_en) begin
            for (int r = 0; r < KERNEL_H; r++) begin
                for (int c = 0; c < KERNEL_W - 2; c++) begin
                    taps[r][c] <= taps[r][c+1];
                end
                taps[r][KERNEL_W-2] <= window[r*KERNEL_W + KERNEL_W - 1];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/pattern_recognition.sv ====
`timescale 1ns/100ps
`default_nettype none

module pattern_recognition (
    input  logic                           clk,
    input  logic                           reset,
    // Camera stream
    input  logic                           x_valid,
    output logic                           x_ready,
    input  vision_pkg::pixel_t             x_data,
    // Filter coefficients
    input  vision_pkg::kernel_t            kernel,
    // Filtered stream
    output logic                           y_valid,
    input  logic                           y_ready,
    output vision_pkg::pixel_t             y_data,
    // Frame verdict
    output logic                           crossing_detected,
    output logic [vision_pkg::COUNT_W-1:0] long_run_count,
    output logic                           detection_valid
);
    import vision_pkg::*;

    logic                         beat;           // Filtered pixel taken downstream
    lane_result_t [NUM_LANES-1:0] lane_results;
    logic [NUM_LANES-1:0]         lane_valid;     // All lanes pulse together

    // ======================================================================
    // 3x3 filter
    // ======================================================================
    convolution_filter u_filter (
        .clk     (clk),
        .reset   (reset),
        .x_valid (x_valid),
        .x_ready (x_ready),
        .x_data  (x_data),
        .kernel  (kernel),
        .y_valid (y_valid),
        .y_ready (y_ready),
        .y_data  (y_data)
    );

    assign beat = y_valid && y_ready;   // Lanes only watch, never stall

    // ======================================================================
    // Detector lanes and vote
    // ======================================================================
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        stripe_detector #(
            .LANE (i)                   // Own whiteness threshold
        ) u_lane (
            .clk          (clk),
            .reset        (reset),
            .beat         (beat),
            .pixel        (y_data),
            .result       (lane_results[i]),
            .result_valid (lane_valid[i])
        );
    end

    crossing_vote u_vote (
        .clk               (clk),
        .reset             (reset),
        .lane_valid        (lane_valid[0]),
        .lanes             (lane_results),
        .crossing_detected (crossing_detected),
        .long_run_count    (long_run_count),
        .detection_valid   (detection_valid)
    );

endmodule

`default_nettype wire

// ==== hw/stripe_detector.sv ====
`timescale 1ns/100ps
`default_nettype none

module stripe_detector #(
    parameter int LANE = 0                       // Selects the lane threshold
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      beat,          // Filtered pixel transferred
    input  vision_pkg::pixel_t        pixel,
    output vision_pkg::lane_result_t  result,
    output logic                      result_valid
);
    import vision_pkg::*;

    localparam logic [PIX_W-1:0] THRESHOLD = LANE_THRESHOLD[LANE];

    // ======================================================================
    // State
    // ======================================================================
    logic [OUT_COL_W-1:0] col;         // Output raster position
    logic [OUT_ROW_W-1:0] row;
    logic [RUN_W-1:0]     run;         // White pixels so far in current run
    logic [COUNT_W-1:0]   count;       // Long runs this frame

    logic                 is_white;
    logic                 last_col;
    logic                 last_row;
    logic                 last_pixel;
    logic [RUN_W-1:0]     closed_len;  // Length if the run ends here
    logic                 run_closes;
    logic                 long_run;
    logic [COUNT_W-1:0]   count_next;

    assign is_white   = (pixel.value >= THRESHOLD);
    assign last_col   = (col == OUT_COL_W'(OUT_WIDTH - 1));
    assign last_row   = (row == OUT_ROW_W'(OUT_HEIGHT - 1));
    assign last_pixel = last_col && last_row;

    // Run ends on a dark pixel, or at row end with this pixel included
    assign closed_len = is_white ? run + 1'b1 : run;
    assign run_closes = !is_white || last_col;
    assign long_run   = run_closes && (closed_len >= RUN_W'(MIN_RUN_LENGTH));

    // Saturates at all ones
    assign count_next = (long_run && (count != '1)) ? count + 1'b1 : count;

    // ======================================================================
    // Run and frame tracking
    // ======================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            col          <= '0;
            row          <= '0;
            run          <= '0;
            count        <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;                       // Single cycle pulse
            if (beat) begin
                if (last_col) begin
                    col <= '0;
                    row <= last_row ? '0 : row + 1'b1;
                    run <= '0;                          // Runs never span rows
                end else begin
                    col <= col + 1'b1;
                    run <= is_white ? run + 1'b1 : '0;
                end
                count        <= last_pixel ? '0 : count_next;   // Fresh frame
                result_valid <= last_pixel;
            end
        end
    end

    // Frame verdict, includes a run closing on the last pixel
    always_ff @(posedge clk) begin
        if (beat && last_pixel) begin
            result.detected       <= (count_next >= COUNT_W'(MIN_STRIPES));
            result.long_run_count <= count_next;
        end
    end

endmodule

`default_nettype wire

// ==== hw/vision_pkg.sv ====
`default_nettype none

package vision_pkg;

    // ======================================================================
    // Frame and kernel geometry
    // ======================================================================
    localparam int IMG_WIDTH  = 16;               // Input pixels per row
    localparam int IMG_HEIGHT = 8;                // Input rows per frame
    localparam int OUT_WIDTH  = IMG_WIDTH - 2;    // Interior columns only
    localparam int OUT_HEIGHT = IMG_HEIGHT - 2;   // Interior rows only

    localparam int KERNEL_H = 3;
    localparam int KERNEL_W = 3;
    localparam int KERNEL_N = KERNEL_H * KERNEL_W;   // Taps per window

    // Raster counter widths
    localparam int COL_W     = $clog2(IMG_WIDTH);
    localparam int ROW_W     = $clog2(IMG_HEIGHT);
    localparam int OUT_COL_W = $clog2(OUT_WIDTH);
    localparam int OUT_ROW_W = $clog2(OUT_HEIGHT);

    // ======================================================================
    // Arithmetic
    // ======================================================================
    localparam int PIX_W  = 8;     // Grey level width
    localparam int W_FRAC = 0;     // Accumulator right shift
    localparam int ACC_W  = 20;    // Room for nine 9x8 signed products

    // ======================================================================
    // Detection
    // ======================================================================
    localparam int NUM_LANES      = 3;
    localparam int COUNT_W        = 8;    // Saturating counts
    localparam int MIN_RUN_LENGTH = 4;    // Shortest white run that counts as a stripe
    localparam int MIN_STRIPES    = 3;    // Long runs needed per frame
    localparam int RUN_W          = $clog2(OUT_WIDTH + 1);

    // Lane 0 loosest, lane 2 strictest
    localparam logic [NUM_LANES-1:0][PIX_W-1:0] LANE_THRESHOLD = {8'd220, 8'd180, 8'd128};

    // One grey pixel on either stream
    typedef struct packed {
        logic [PIX_W-1:0] value;   // Unsigned
    } pixel_t;

    typedef logic signed [PIX_W-1:0] coef_t;

    // Row-major, index row*KERNEL_W + col, index 0 is top left
    typedef struct packed {
        coef_t [KERNEL_N-1:0] coef;
    } kernel_t;

    // Per-lane frame verdict
    typedef struct packed {
        logic               detected;         // Enough long runs this frame
        logic [COUNT_W-1:0] long_run_count;
    } lane_result_t;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the pattern_recognition testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pattern_recognition -f files.f

output=$(./obj_dir/Vtb_pattern_recognition 2>&1 || true)
echo "$output"

if echo "$output" | grep -q "All tests passed!"; then
    exit 0
else
    exit 1
fi
